//--- hdl/aluExecPkg.sv
package aluExecPkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////
  localparam int dataWidth   = 16;                // One data word
  localparam int regCount    = 16;                // General registers
  localparam int regIdxWidth = $clog2(regCount);  // Register select field
  localparam int opWidth     = 4;
  localparam int immWidth    = 4;
  localparam int addrWidth   = 7;                 // APB byte address

  // Opcodes
  localparam logic [opWidth-1:0] opAdd    = 4'h0;
  localparam logic [opWidth-1:0] opSub    = 4'h1;
  localparam logic [opWidth-1:0] opXor    = 4'h2;
  localparam logic [opWidth-1:0] opRed    = 4'h3;
  localparam logic [opWidth-1:0] opSll    = 4'h4;
  localparam logic [opWidth-1:0] opSra    = 4'h5;
  localparam logic [opWidth-1:0] opRor    = 4'h6;
  localparam logic [opWidth-1:0] opPaddsb = 4'h7;
  localparam logic [opWidth-1:0] opLw     = 4'h8;
  localparam logic [opWidth-1:0] opSw     = 4'h9;

  // Register map, byte addresses
  localparam logic [addrWidth-1:0] regBase  = 7'h00;  // 0x00..0x3C, word aligned
  localparam logic [addrWidth-1:0] cmdAddr  = 7'h40;  // Write only
  localparam logic [addrWidth-1:0] flagAddr = 7'h44;  // Read only
  localparam logic [addrWidth-1:0] errAddr  = 7'h48;  // Any write clears

  // Bit positions in the FLAGS word
  localparam int flagNBit = 2;
  localparam int flagVBit = 1;
  localparam int flagZBit = 0;

  // Saturation limits
  localparam logic [dataWidth-1:0] satPos = 16'h7FFF;
  localparam logic [dataWidth-1:0] satNeg = 16'h8000;

  //////////////////////////////////////////////////
  // Instruction word
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [opWidth-1:0]     opcode;
    logic [regIdxWidth-1:0] rd;
    logic [regIdxWidth-1:0] rs;
    logic [regIdxWidth-1:0] rt;
  } rFmtT;

  typedef struct packed {
    logic [opWidth-1:0]     opcode;
    logic [regIdxWidth-1:0] rd;
    logic [regIdxWidth-1:0] rs;
    logic [immWidth-1:0]    imm;     // Shift amount or signed word offset
  } iFmtT;

  typedef union packed {
    rFmtT rFmt;  // Register-register view
    iFmtT iFmt;  // Immediate view
  } instrWord;

endpackage

//--- hdl/claAdder16.sv
`timescale 1ns/1ps
`default_nettype none

module claAdder16 import aluExecPkg::*; (
  input  logic [dataWidth-1:0] a,
  input  logic [dataWidth-1:0] b,
  input  logic                 sub,      // 1 = a - b
  output logic [dataWidth-1:0] sum,
  output logic                 posOvfl,  // Wrapped past max positive
  output logic                 negOvfl   // Wrapped past min negative
);

  logic [dataWidth-1:0] bEff;               // b after optional inversion
  logic [dataWidth-1:0] gen;
  logic [dataWidth-1:0] prop;
  logic [dataWidth-1:0] carry;              // Carry into each bit
  logic [2:0]           grpGen, grpProp;    // Top group output not needed
  logic [3:0]           grpCin;             // Carry into each 4-bit group

  assign bEff = sub ? ~b : b;               // +1 comes in as carry
  assign gen  = a & bEff;
  assign prop = a ^ bEff;

  // Group generate and propagate, lower three groups
  always_comb begin
    for (int k = 0; k < 3; k++) begin
      grpProp[k] = &prop[4*k +: 4];
      grpGen[k]  = gen[4*k+3] | (prop[4*k+3] & gen[4*k+2]) |
                   (prop[4*k+3] & prop[4*k+2] & gen[4*k+1]) |
                   (prop[4*k+3] & prop[4*k+2] & prop[4*k+1] & gen[4*k]);
    end
  end

  //////////////////////////////////////////////////
  // Second level lookahead
  //////////////////////////////////////////////////
  assign grpCin[0] = sub;
  assign grpCin[1] = grpGen[0] | (grpProp[0] & sub);
  assign grpCin[2] = grpGen[1] | (grpProp[1] & grpGen[0]) |
                     (grpProp[1] & grpProp[0] & sub);
  assign grpCin[3] = grpGen[2] | (grpProp[2] & grpGen[1]) |
                     (grpProp[2] & grpProp[1] & grpGen[0]) | (&grpProp & sub);

  // Bit carries inside a group
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      carry[4*k] = grpCin[k];
      for (int j = 1; j < 4; j++) begin
        carry[4*k+j] = gen[4*k+j-1] | (prop[4*k+j-1] & carry[4*k+j-1]);
      end
    end
  end

  assign sum = prop ^ carry;

  // Sign based overflow on the effective operands
  assign posOvfl = ~a[dataWidth-1] & ~bEff[dataWidth-1] & sum[dataWidth-1];
  assign negOvfl = a[dataWidth-1] & bEff[dataWidth-1] & ~sum[dataWidth-1];

endmodule

`default_nettype wire

//--- hdl/psaAdder16.sv
`timescale 1ns/1ps
`default_nettype none

module psaAdder16 import aluExecPkg::*; (
  input  logic [dataWidth-1:0] a,
  input  logic [dataWidth-1:0] b,
  output logic [dataWidth-1:0] sum
);

  logic signed [4:0] nibSum [4];  // Raw nibble sums, one guard bit

  // Each nibble lane is independent, no carry between lanes
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      nibSum[k] = $signed({a[4*k+3], a[4*k +: 4]}) +
                  $signed({b[4*k+3], b[4*k +: 4]});
      if (nibSum[k] > 5'sd7) begin
        sum[4*k +: 4] = 4'h7;              // Clamp to +7
      end else if (nibSum[k] < -5'sd8) begin
        sum[4*k +: 4] = 4'h8;              // Clamp to -8
      end else begin
        sum[4*k +: 4] = nibSum[k][3:0];    // In range
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/redUnit.sv
`timescale 1ns/1ps
`default_nettype none

module redUnit import aluExecPkg::*; (
  input  logic [dataWidth-1:0] a,
  input  logic [dataWidth-1:0] b,
  output logic [dataWidth-1:0] sum
);

  logic signed [8:0] hiSum;   // a[15:8] + b[15:8]
  logic signed [8:0] loSum;   // a[7:0] + b[7:0]
  logic signed [9:0] total;   // -512..508, never wraps

  //////////////////////////////////////////////////
  // Two level adder tree over signed bytes
  //////////////////////////////////////////////////
  assign hiSum = $signed({a[15], a[15:8]}) + $signed({b[15], b[15:8]});
  assign loSum = $signed({a[7], a[7:0]}) + $signed({b[7], b[7:0]});

  // Second level, one more guard bit
  assign total = $signed({hiSum[8], hiSum}) + $signed({loSum[8], loSum});

  // No saturation, just sign extend
  assign sum = {{(dataWidth-10){total[9]}}, total};

endmodule

`default_nettype wire

//--- hdl/shifter16.sv
`timescale 1ns/1ps
`default_nettype none

module shifter16 import aluExecPkg::*; (
  input  logic [dataWidth-1:0] shiftIn,
  input  logic [1:0]           mode,      // 0 SLL, 1 SRA, 2 ROR
  input  logic [3:0]           amount,
  output logic [dataWidth-1:0] shiftOut
);

  logic [dataWidth-1:0] stage [5];        // stage[s] feeds shift by 2**s

  // Log shifter, stage s shifts by 1, 2, 4 or 8
  always_comb begin
    stage[0] = shiftIn;
    for (int s = 0; s < 4; s++) begin
      if (amount[s]) begin
        case (mode)
          2'd0: stage[s+1] = stage[s] << (1 << s);
          2'd1: stage[s+1] = $signed(stage[s]) >>> (1 << s);   // Sign fill
          2'd2: stage[s+1] = (stage[s] >> (1 << s)) |
                             (stage[s] << (dataWidth - (1 << s)));
          default: stage[s+1] = stage[s];                     // Unused mode
        endcase
      end else begin
        stage[s+1] = stage[s];  // Bypass
      end
    end
  end

  assign shiftOut = stage[4];

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import aluExecPkg::*; (
  input  logic [opWidth-1:0]   opcode,
  input  logic [dataWidth-1:0] opA,
  input  logic [dataWidth-1:0] opB,
  output logic [dataWidth-1:0] result,
  output logic                 nFlag,
  output logic                 vFlag,
  output logic                 zFlag,
  output logic                 nvUpd,    // Load N and V
  output logic                 zUpd,     // Load Z
  output logic                 illegal   // Opcode 0xA..0xF
);

  logic                 memOp;       // LW or SW address calc
  logic [dataWidth-1:0] addA, addB;
  logic [dataWidth-1:0] rawSum, satSum;
  logic                 posOvfl, negOvfl;
  logic [dataWidth-1:0] xorOut, psaOut, redOut, shiftOut;

  //////////////////////////////////////////////////
  // Adder path shared by ADD, SUB, LW and SW
  //////////////////////////////////////////////////
  assign memOp = (opcode == opLw) || (opcode == opSw);
  assign addA  = memOp ? {opA[dataWidth-1:1], 1'b0} : opA;  // Word aligned base
  assign addB  = memOp ? (opB << 1) : opB;                  // Offset in words

  claAdder16 u_claAdder16 (
    .a       (addA),
    .b       (addB),
    .sub     (opcode == opSub),
    .sum     (rawSum),
    .posOvfl (posOvfl),
    .negOvfl (negOvfl)
  );

  assign satSum = posOvfl ? satPos : negOvfl ? satNeg : rawSum;

  assign xorOut = opA ^ opB;

  psaAdder16 u_psaAdder16 (.a(opA), .b(opB), .sum(psaOut));

  redUnit u_redUnit (.a(opA), .b(opB), .sum(redOut));

  // Mode from the low opcode bits and amount from the low imm bits
  shifter16 u_shifter16 (
    .shiftIn  (opA),
    .mode     (opcode[1:0]),
    .amount   (opB[3:0]),
    .shiftOut (shiftOut)
  );

  //////////////////////////////////////////////////
  // Result select and flag enables
  //////////////////////////////////////////////////
  always_comb begin
    result  = '0;
    nvUpd   = 1'b0;
    zUpd    = 1'b0;
    illegal = 1'b0;
    case (opcode)
      opAdd, opSub: begin
        result = satSum;
        nvUpd  = 1'b1;
        zUpd   = 1'b1;
      end
      opXor: begin
        result = xorOut;
        zUpd   = 1'b1;
      end
      opSll, opSra, opRor: begin
        result = shiftOut;
        zUpd   = 1'b1;
      end
      opRed:      result = redOut;      // No flags
      opPaddsb:   result = psaOut;      // No flags
      opLw, opSw: result = satSum;      // Address only
      default:    illegal = 1'b1;
    endcase
  end

  assign nFlag = satSum[dataWidth-1];  // Sign of the saturated sum
  assign vFlag = posOvfl | negOvfl;
  assign zFlag = (result == '0);

endmodule

`default_nettype wire

//--- hdl/apbRegs.sv
`timescale 1ns/1ps
`default_nettype none

module apbRegs import aluExecPkg::*; (
  input  logic                   clk,
  input  logic                   rstN,
  // APB slave
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [addrWidth-1:0]   paddr,
  input  logic [dataWidth-1:0]   pwdata,
  output logic [dataWidth-1:0]   prdata,
  output logic                   pready,
  output logic                   pslverr,
  // Writeback port
  input  logic                   wbEn,
  input  logic [regIdxWidth-1:0] wbAddr,
  input  logic [dataWidth-1:0]   wbData,
  // Status readback
  input  logic [2:0]             flags,
  input  logic                   errBit,
  // Issue
  output logic                   issueValid,
  output logic [opWidth-1:0]     opcode,
  output logic [regIdxWidth-1:0] rd,
  output logic [dataWidth-1:0]   opA,
  output logic [dataWidth-1:0]   opB,
  output logic                   errClr
);

  logic [dataWidth-1:0]   regFile [regCount];
  logic                   access, wrAcc, rdAcc;
  logic [addrWidth-1:0]   regOfs;            // Offset from register base
  logic [regIdxWidth-1:0] regIdx;
  logic                   regHit, cmdHit, flagHit, errHit;
  logic                   hostRegWr;
  instrWord               cmd;               // pwdata seen as an instruction
  logic [dataWidth-1:0]   immSext, immZext;

  //////////////////////////////////////////////////
  // APB decode
  //////////////////////////////////////////////////
  assign access = psel & penable;           // Access phase completes at this edge
  assign wrAcc  = access & pwrite;
  assign rdAcc  = access & ~pwrite;

  assign regOfs  = paddr - regBase;
  assign regIdx  = regOfs[2 +: regIdxWidth];
  assign regHit  = (regOfs < addrWidth'(4 * regCount)) && (regOfs[1:0] == 2'b00);
  assign cmdHit  = (paddr == cmdAddr);
  assign flagHit = (paddr == flagAddr);
  assign errHit  = (paddr == errAddr);

  assign hostRegWr = wrAcc & regHit;

  assign pready  = 1'b1;                                   // No wait states
  assign pslverr = (rdAcc & cmdHit) | (wrAcc & flagHit);   // CMD is write only and FLAGS read only

  assign prdata = regHit  ? regFile[regIdx] :
                  flagHit ? dataWidth'(flags) :
                  errHit  ? dataWidth'(errBit) : '0;

  // Register file with host and writeback ports
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < regCount; i++) begin
        regFile[i] <= '0;
      end
    end else begin
      if (hostRegWr) begin
        regFile[regIdx] <= pwdata;
      end
      if (wbEn) begin
        regFile[wbAddr] <= wbData;
      end
    end
  end

  //////////////////////////////////////////////////
  // Issue stage
  //////////////////////////////////////////////////
  assign cmd     = pwdata;
  assign immSext = {{(dataWidth-immWidth){cmd.iFmt.imm[immWidth-1]}}, cmd.iFmt.imm};
  assign immZext = dataWidth'(cmd.iFmt.imm);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      issueValid <= 1'b0;
      errClr     <= 1'b0;
    end else begin
      issueValid <= wrAcc & cmdHit;  // One cycle pulse per command
      errClr     <= wrAcc & errHit;
    end
  end

  // Operand capture at the command edge
  always_ff @(posedge clk) begin
    if (wrAcc && cmdHit) begin
      opcode <= cmd.rFmt.opcode;
      rd     <= cmd.rFmt.rd;
      opA    <= regFile[cmd.rFmt.rs];
      case (cmd.rFmt.opcode)
        opLw, opSw:          opB <= immSext;                // Signed word offset
        opSll, opSra, opRor: opB <= immZext;                // Shift amount
        default:             opB <= regFile[cmd.rFmt.rt];
      endcase
    end
  end

  // Back-to-back commands are impossible under APB timing
  issuePulse: assert property (@(posedge clk) disable iff (!rstN)
    issueValid |=> !issueValid);

  // Host writes and writeback are kept apart by APB timing
  wbHostClash: assert property (@(posedge clk) disable iff (!rstN)
    !(wbEn && hostRegWr && (wbAddr == regIdx)));

endmodule

`default_nettype wire

//--- hdl/flagWriteback.sv
`timescale 1ns/1ps
`default_nettype none

module flagWriteback import aluExecPkg::*; (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   issueValid,
  input  logic [regIdxWidth-1:0] rd,
  input  logic [dataWidth-1:0]   result,
  input  logic                   nFlag,
  input  logic                   vFlag,
  input  logic                   zFlag,
  input  logic                   nvUpd,
  input  logic                   zUpd,
  input  logic                   illegal,
  input  logic                   errClr,
  output logic                   wbEn,
  output logic [regIdxWidth-1:0] wbAddr,
  output logic [dataWidth-1:0]   wbData,
  output logic [2:0]             flags,    // {N, V, Z}
  output logic                   errBit    // Sticky illegal opcode
);

  //////////////////////////////////////////////////
  // Writeback lands in the register file at E0+1
  //////////////////////////////////////////////////
  assign wbEn   = issueValid & ~illegal;   // Illegal ops write nothing
  assign wbAddr = rd;
  assign wbData = result;

  // Only the flags the op defines are loaded
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flags <= '0;
    end else if (issueValid) begin
      if (nvUpd) begin
        flags[flagNBit] <= nFlag;
        flags[flagVBit] <= vFlag;
      end
      if (zUpd) begin
        flags[flagZBit] <= zFlag;
      end
    end
  end

  // Sticky error bit where a set wins over a clear
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      errBit <= 1'b0;
    end else if (issueValid && illegal) begin
      errBit <= 1'b1;
    end else if (errClr) begin
      errBit <= 1'b0;
    end
  end

  // Flags hold and no write comes next after an illegal issue
  illegalNoWb: assert property (@(posedge clk) disable iff (!rstN)
    (issueValid && illegal) |=> (!wbEn && $stable(flags)));

endmodule

`default_nettype wire

//--- hdl/aluExecTop.sv
`timescale 1ns/1ps
`default_nettype none

module aluExecTop import aluExecPkg::*; (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [addrWidth-1:0] paddr,
  input  logic [dataWidth-1:0] pwdata,
  output logic [dataWidth-1:0] prdata,
  output logic                 pready,
  output logic                 pslverr
);

  // Issue side
  logic                   issueValid;
  logic [opWidth-1:0]     opcode;
  logic [regIdxWidth-1:0] rd;
  logic [dataWidth-1:0]   opA, opB;
  logic                   errClr;
  // ALU outputs
  logic [dataWidth-1:0]   result;
  logic                   nFlag, vFlag, zFlag;
  logic                   nvUpd, zUpd, illegal;
  // Writeback and status
  logic                   wbEn;
  logic [regIdxWidth-1:0] wbAddr;
  logic [dataWidth-1:0]   wbData;
  logic [2:0]             flags;
  logic                   errBit;

  apbRegs u_apbRegs (
    .clk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .wbEn, .wbAddr, .wbData, .flags, .errBit,
    .issueValid, .opcode, .rd, .opA, .opB, .errClr
  );

  alu u_alu (
    .opcode, .opA, .opB, .result,
    .nFlag, .vFlag, .zFlag, .nvUpd, .zUpd, .illegal
  );

  flagWriteback u_flagWriteback (
    .clk, .rstN, .issueValid, .rd, .result,
    .nFlag, .vFlag, .zFlag, .nvUpd, .zUpd, .illegal, .errClr,
    .wbEn, .wbAddr, .wbData, .flags, .errBit
  );

endmodule

`default_nettype wire

//--- dv/aluExecTb.sv
`timescale 1ns/1ps

module aluExecTb import aluExecPkg::*; ();

  localparam int waitLimit = 20;   // Cycles allowed for any wait
  localparam int randCount = 80;   // Random legal instructions

  logic                 clk, rstN, psel, penable, pwrite;
  logic [addrWidth-1:0] paddr;
  logic [dataWidth-1:0] pwdata, prdata;
  logic                 pready, pslverr;

  logic [dataWidth-1:0] modelRegs [regCount];   // Shadow register file
  logic [2:0]           modelFlags;             // {N, V, Z}
  logic                 modelErr;
  logic [31:0]          rngState;
  int                   errCount, checkCount;
  string                nameQ [$];              // Pending checks
  logic [dataWidth-1:0] expQ [$], actQ [$];

  aluExecTop u_aluExecTop (
    .clk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] drawRand();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  function automatic logic [addrWidth-1:0] regAddr(input int idx);
    return regBase + addrWidth'(4 * idx);  // Word aligned
  endfunction

  // Expected outcome, packed as {illegal, nvUpd, zUpd, N, V, Z, result}
  function automatic logic [21:0] refAlu(input logic [3:0] op, input logic [15:0] a,
                                         input logic [15:0] b);
    int          sum, lane;
    logic [15:0] res;
    logic [31:0] twice;
    logic        ovf, nvEn, zEn, bad;
    res  = 16'h0000;
    sum  = 0;
    ovf  = 1'b0;
    nvEn = 1'b0;
    zEn  = 1'b0;
    bad  = 1'b0;
    case (op)
      opAdd, opSub, opLw, opSw: begin
        if (op == opAdd) sum = int'($signed(a)) + int'($signed(b));
        else if (op == opSub) sum = int'($signed(a)) - int'($signed(b));
        else sum = int'($signed({a[15:1], 1'b0})) + 2 * int'($signed(b));  // Word offset
        if (sum > 32767) begin
          res = 16'h7FFF;
          ovf = 1'b1;
        end else if (sum < -32768) begin
          res = 16'h8000;
          ovf = 1'b1;
        end else begin
          res = 16'(sum);
        end
        nvEn = (op == opAdd) || (op == opSub);
        zEn  = nvEn;
      end
      opXor: begin
        res = a ^ b;
        zEn = 1'b1;
      end
      opRed: begin
        sum = int'($signed(a[15:8])) + int'($signed(a[7:0])) +
              int'($signed(b[15:8])) + int'($signed(b[7:0]));
        res = 16'(sum);  // Wide enough, never clamps
      end
      opSll, opSra, opRor: begin
        twice = {a, a} >> b[3:0];
        if (op == opSll) res = a << b[3:0];
        else if (op == opSra) res = $signed(a) >>> b[3:0];
        else res = twice[15:0];
        zEn = 1'b1;
      end
      opPaddsb: begin
        for (int k = 0; k < 4; k++) begin
          lane = int'($signed(a[4*k +: 4])) + int'($signed(b[4*k +: 4]));
          if (lane > 7) lane = 7;
          else if (lane < -8) lane = -8;
          res[4*k +: 4] = lane[3:0];
        end
      end
      default: bad = 1'b1;  // 0xA..0xF
    endcase
    return {bad, nvEn, zEn, res[15], ovf, (res == 16'h0000), res};
  endfunction

  task automatic checkVal(input string name, input logic [15:0] expVal,
                          input logic [15:0] actVal);
    checkCount++;
    if (actVal !== expVal) begin
      errCount++;
      $display("** Error: test %s expected 0x%h actual 0x%h", name, expVal, actVal);
    end
  endtask

  task automatic pushCheck(input string name, input logic [15:0] expVal,
                           input logic [15:0] actVal);
    nameQ.push_back(name);
    expQ.push_back(expVal);
    actQ.push_back(actVal);
  endtask

  //////////////////////////////////////////////////
  // APB master
  //////////////////////////////////////////////////
  task automatic runTransfer(input logic wr, input logic [addrWidth-1:0] addr,
                             input logic [15:0] wdata, output logic [15:0] rdata,
                             output logic err);
    int waitCnt;
    @(negedge clk);                     // Setup phase
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;                     // Access phase
    #1;
    waitCnt = 0;
    while (!pready && waitCnt < waitLimit) begin
      @(negedge clk);
      #1;
      waitCnt++;
    end
    if (!pready) begin
      $display("Timeout: pready stayed low on APB access to 0x%h", addr);
      $display("TEST FAIL");
      $finish;
    end else begin
      rdata = prdata;                   // Stable mid cycle
      err   = pslverr;
      @(posedge clk);                   // Transfer completes
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
    end
  endtask

  task automatic apbWrite(input logic [addrWidth-1:0] addr, input logic [15:0] data,
                          output logic err);
    logic [15:0] unused;
    runTransfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apbRead(input logic [addrWidth-1:0] addr, output logic [15:0] data,
                         output logic err);
    runTransfer(1'b0, addr, 16'h0000, data, err);
  endtask

  task automatic writeReg(input int idx, input logic [15:0] value);
    logic err;
    apbWrite(regAddr(idx), value, err);
    modelRegs[idx] = value;
    pushCheck("reg write slverr", 16'h0000, {15'h0, err});
  endtask

  // Reads back every register, FLAGS and ERR
  task automatic verifyState(input string name);
    logic [15:0] rdata;
    logic        err;
    for (int i = 0; i < regCount; i++) begin
      apbRead(regAddr(i), rdata, err);
      pushCheck({name, " reg"}, modelRegs[i], rdata);
    end
    apbRead(flagAddr, rdata, err);
    pushCheck({name, " flags"}, {13'h0, modelFlags}, rdata);
    apbRead(errAddr, rdata, err);
    pushCheck({name, " err"}, {15'h0, modelErr}, rdata);
  endtask

  // Issue one instruction, update the model, read rd, FLAGS and ERR
  task automatic issueCmd(input string name, input logic [3:0] op, input logic [3:0] rd,
                          input logic [3:0] rs, input logic [3:0] field);
    logic [15:0] a, b, rdata;
    logic [21:0] expOut;
    logic        err;
    a = modelRegs[rs];
    if (op == opLw || op == opSw) b = {{12{field[3]}}, field};       // Signed offset
    else if (op == opSll || op == opSra || op == opRor) b = {12'h000, field};
    else b = modelRegs[field];
    expOut = refAlu(op, a, b);
    if (expOut[21]) begin
      modelErr = 1'b1;                  // Nothing else changes
    end else begin
      modelRegs[rd] = expOut[15:0];
      if (expOut[20]) modelFlags[2:1] = expOut[18:17];
      if (expOut[19]) modelFlags[0] = expOut[16];
    end
    apbWrite(cmdAddr, {op, rd, rs, field}, err);
    pushCheck({name, " cmd slverr"}, 16'h0000, {15'h0, err});
    apbRead(regAddr(int'(rd)), rdata, err);
    pushCheck({name, " rd"}, modelRegs[rd], rdata);
    apbRead(flagAddr, rdata, err);
    pushCheck({name, " flags"}, {13'h0, modelFlags}, rdata);
    apbRead(errAddr, rdata, err);
    pushCheck({name, " err"}, {15'h0, modelErr}, rdata);
  endtask

  // Compare process
  always @(negedge clk) begin
    while (nameQ.size() > 0) begin
      checkVal(nameQ.pop_front(), expQ.pop_front(), actQ.pop_front());
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    logic [31:0] rnd;
    logic [15:0] rdata;
    logic        err;
    int          waitCnt;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    rstN       = 1'b0;
    rngState   = 32'd44642;
    errCount   = 0;
    checkCount = 0;
    modelFlags = 3'b000;
    modelErr   = 1'b0;
    for (int i = 0; i < regCount; i++) modelRegs[i] = 16'h0000;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    // Register file round trip
    for (int i = 0; i < regCount; i++) begin
      rnd = drawRand();
      writeReg(i, rnd[15:0]);
    end
    verifyState("regfile");

    // Random legal ops, a register reseeded now and then
    for (int k = 0; k < randCount; k++) begin
      rnd = drawRand();
      if (k % 8 == 0) writeReg(int'(rnd[19:16]), rnd[31:16]);
      issueCmd("random", 4'(rnd % 32'd10), rnd[7:4], rnd[11:8], rnd[15:12]);
    end

    // Saturation corners
    writeReg(1, 16'h7FFF);
    writeReg(2, 16'h0001);
    writeReg(3, 16'h8000);
    issueCmd("add sat", opAdd, 4'd4, 4'd1, 4'd2);
    issueCmd("sub sat", opSub, 4'd5, 4'd3, 4'd2);
    issueCmd("lw sat", opLw, 4'd6, 4'd1, 4'h7);
    writeReg(7, 16'h7777);
    writeReg(8, 16'h1111);
    writeReg(9, 16'h8888);
    writeReg(10, 16'hFFFF);
    issueCmd("paddsb pos", opPaddsb, 4'd11, 4'd7, 4'd8);
    issueCmd("paddsb neg", opPaddsb, 4'd11, 4'd9, 4'd10);
    writeReg(12, 16'h8080);
    writeReg(13, 16'h7F7F);
    issueCmd("red min", opRed, 4'd14, 4'd12, 4'd12);
    issueCmd("red max", opRed, 4'd14, 4'd13, 4'd13);

    // Shifts on a negative and a positive value
    writeReg(1, 16'h9A35);
    writeReg(2, 16'h3A5C);
    for (int amt = 0; amt < 16; amt++) begin
      for (int src = 1; src <= 2; src++) begin
        for (int op = int'(opSll); op <= int'(opRor); op++) begin
          issueCmd("shift", 4'(op), 4'd3, 4'(src), 4'(amt));
        end
      end
    end

    // Illegal opcodes, then clear ERR
    for (int op = 10; op < 16; op++) begin
      issueCmd("illegal", 4'(op), 4'(op - 8), 4'd1, 4'd2);
    end
    apbWrite(errAddr, 16'h0000, err);
    modelErr = 1'b0;
    apbRead(errAddr, rdata, err);
    pushCheck("err clear", 16'h0000, rdata);

    // Bad accesses leave every register alone
    apbRead(cmdAddr, rdata, err);
    pushCheck("cmd read slverr", 16'h0001, {15'h0, err});
    apbWrite(flagAddr, {13'h0, ~modelFlags}, err);
    pushCheck("flag write slverr", 16'h0001, {15'h0, err});
    verifyState("bad access");

    waitCnt = 0;
    while (nameQ.size() != 0 && waitCnt < waitLimit) begin
      @(negedge clk);
      waitCnt++;
    end
    if (nameQ.size() != 0) begin
      $display("Compare queue still holds %0d checks at the end", nameQ.size());
      errCount++;
    end
    $display("Checks run: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- aluExecTop.f
hdl/aluExecPkg.sv
hdl/claAdder16.sv
hdl/psaAdder16.sv
hdl/redUnit.sv
hdl/shifter16.sv
hdl/alu.sv
hdl/apbRegs.sv
hdl/flagWriteback.sv
hdl/aluExecTop.sv
dv/aluExecTb.sv

//--- build.sh
#!/bin/sh
# Build and run the aluExecTop testbench with Verilator
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module aluExecTb -f aluExecTop.f -o simv \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/simv > sim.log 2>&1
cat sim.log

grep -q "TEST FAIL" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
